/* Makefile */
# Verilator build and run of the ROM download path testbench
# Override any variable on the command line, e.g. make BUILD_DIR=obj

VERILATOR  ?= verilator
TOP        ?= tb_kicker_rom_load
FILELIST   ?= project.f
BUILD_DIR  ?= build
LOG        ?= sim.log
PASS_TEXT  ?= Everything OK
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/kicker_dwnld.sv */
// Stage 1 of the ROM download path: takes loader bytes and sorts them by region
// SDRAM bytes go out as word writes, PROM bytes go straight to the PROM port

module kicker_dwnld (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            downloading,
    input  logic [kicker_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                      ioctl_dout,
    input  logic                            ioctl_wr,
    output logic                            ioctl_ready,
    output logic                            prom_we,
    output logic [kicker_pkg::PROM_AW-1:0]  prom_addr,
    output logic [7:0]                      prom_data,
    prog_if.source                          out
);
    import kicker_pkg::*;

    logic                rdy_en;    // Low only in the cycle reset is applied
    region_e             region;
    logic                accept;
    logic [IOCTL_AW-1:0] prom_off;

    always_comb begin
        if (ioctl_addr < IOCTL_AW'(SCR_START)) begin
            region = REG_MAIN;
        end else if (ioctl_addr < IOCTL_AW'(OBJ_START)) begin
            region = REG_SCR;
        end else if (ioctl_addr < IOCTL_AW'(PROM_START)) begin
            region = REG_OBJ;
        end else begin
            region = REG_PROM;
        end
    end

    assign prom_off    = ioctl_addr - IOCTL_AW'(PROM_START);
    assign ioctl_ready = rdy_en & downloading & (~out.valid | out.ready);
    assign accept      = ioctl_wr & ioctl_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rdy_en    <= 1'b0;
            out.valid <= 1'b0;
            prom_we   <= 1'b0;
        end else begin
            rdy_en  <= 1'b1;
            prom_we <= accept && region == REG_PROM;    // Single cycle pulse
            if (accept && region != REG_PROM) begin
                out.valid <= 1'b1;
            end else if (out.ready) begin
                out.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && region != REG_PROM) begin
            out.addr   <= ioctl_addr[PROG_AW:1];            // Byte address halved
            out.mask   <= {~ioctl_addr[0], ioctl_addr[0]};  // Even bytes in lane 0
            out.data   <= ioctl_dout;
            out.region <= region;
        end
        if (accept && region == REG_PROM) begin
            prom_addr <= prom_off[PROM_AW-1:0];
            prom_data <= ioctl_dout;
        end
    end

    // Loader must wait for ready before writing
    a_wr_when_ready: assert property (@(posedge clk) disable iff (reset)
        ioctl_wr |-> ioctl_ready);

    a_payload_held: assert property (@(posedge clk) disable iff (reset)
        out.valid && !out.ready |=> out.valid && $stable(out.addr) && $stable(out.data)
            && $stable(out.mask) && $stable(out.region));

endmodule

/* hdl/kicker_gfx_reorder.sv */
// Stage 2 of the ROM download path: swaps word address bits of graphics tiles
// so the tile fetchers read a whole row in one burst

module kicker_gfx_reorder (
    input  logic   clk,
    input  logic   reset,
    prog_if.sink   in,
    prog_if.source out
);
    import kicker_pkg::*;

    prog_word_u nxt_addr;
    logic       take;

    always_comb begin
        nxt_addr = in.addr;
        case (in.region)
            REG_SCR: begin
                // Row bits move up, inverted column half lands on bit 0
                {nxt_addr.scr.col, nxt_addr.scr.row} = {in.addr.scr.row, ~in.addr.scr.col};
            end
            REG_OBJ: begin
                // Sprite half stays on bit 5
                {nxt_addr.obj.line, nxt_addr.obj.col, nxt_addr.obj.row} =
                    {in.addr.obj.row, in.addr.obj.line, ~in.addr.obj.col};
            end
            default: begin
                nxt_addr = in.addr;     // Main code as is
            end
        endcase
    end

    assign in.ready = ~out.valid | out.ready;
    assign take     = in.valid & in.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else if (take) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out.addr   <= nxt_addr;
            out.data   <= in.data;
            out.mask   <= in.mask;
            out.region <= in.region;
        end
    end

    // PROM bytes are diverted in stage 1
    a_no_prom: assert property (@(posedge clk) disable iff (reset)
        in.valid |-> in.region != REG_PROM);

endmodule

/* hdl/kicker_pkg.sv */
// Shared constants and types for the ROM download path
// Region boundaries follow the loader byte map of the game ROM set

package kicker_pkg;

    localparam int IOCTL_AW = 25;   // Loader byte address
    localparam int PROG_AW  = 22;   // SDRAM word address
    localparam int PROM_AW  = 11;   // 2 KB of colour PROMs

    // Loader byte map, main code starts at zero
    localparam int SCR_START  = 'h08000;
    localparam int OBJ_START  = 'h0C000;
    localparam int PROM_START = 'h10000;

    typedef enum logic [1:0] {
        REG_MAIN,
        REG_SCR,
        REG_OBJ,
        REG_PROM
    } region_e;

    // Same SDRAM word seen by the scroll and the object tile fetchers
    typedef union packed {
        struct packed {
            logic [PROG_AW-5:0] upper;
            logic               col;    // Column half
            logic [2:0]         row;
        } scr;
        struct packed {
            logic [PROG_AW-7:0] upper;
            logic               half;   // Sprite half
            logic               line;
            logic               col;
            logic [2:0]         row;
        } obj;
    } prog_word_u;

endpackage

/* hdl/kicker_rom_load.sv */
// ROM download path of the game core, from loader bytes to SDRAM and PROM writes
// Three stages joined by valid/ready links

module kicker_rom_load (
    input  logic                            clk,
    input  logic                            reset,
    // Loader
    input  logic                            downloading,
    input  logic [kicker_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                      ioctl_dout,
    input  logic                            ioctl_wr,
    output logic                            ioctl_ready,
    output logic                            dwnld_busy,
    // Colour PROMs
    output logic                            prom_we,
    output logic [kicker_pkg::PROM_AW-1:0]  prom_addr,
    output logic [7:0]                      prom_data,
    // SDRAM programming port
    input  logic                            sdram_ack,
    output logic                            prog_we,
    output logic [kicker_pkg::PROG_AW-1:0]  prog_addr,
    output logic [7:0]                      prog_data,
    output logic [1:0]                      prog_mask
);

    logic wr_busy;

    prog_if s1_s2 ();
    prog_if s2_s3 ();

    // Busy until the last write has left every stage
    assign dwnld_busy = downloading | s1_s2.valid | s2_s3.valid | wr_busy;

    kicker_dwnld u_dwnld (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_ready ( ioctl_ready ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   ),
        .prom_data   ( prom_data   ),
        .out         ( s1_s2       )
    );

    kicker_gfx_reorder u_reorder (
        .clk   ( clk   ),
        .reset ( reset ),
        .in    ( s1_s2 ),
        .out   ( s2_s3 )
    );

    kicker_sdram_wr u_sdram_wr (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .in        ( s2_s3     ),
        .sdram_ack ( sdram_ack ),
        .prog_we   ( prog_we   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_mask ( prog_mask ),
        .busy      ( wr_busy   )
    );

endmodule

/* hdl/kicker_sdram_wr.sv */
// Stage 3 of the ROM download path: drives the SDRAM programming port
// A write stays on prog_we until the controller returns sdram_ack

module kicker_sdram_wr (
    input  logic                           clk,
    input  logic                           reset,
    prog_if.sink                           in,
    input  logic                           sdram_ack,
    output logic                           prog_we,
    output logic [kicker_pkg::PROG_AW-1:0] prog_addr,
    output logic [7:0]                     prog_data,
    output logic [1:0]                     prog_mask,
    output logic                           busy
);

    logic load;

    // Free when empty or when the held write is acknowledged now
    assign in.ready = ~prog_we | sdram_ack;
    assign load     = in.valid & in.ready;
    assign busy     = prog_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else if (load) begin
            prog_we <= 1'b1;    // Back to back writes keep prog_we up
        end else if (sdram_ack) begin
            prog_we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            prog_addr <= in.addr;
            prog_data <= in.data;
            prog_mask <= in.mask;
        end
    end

    // SDRAM controller may sample the request on any cycle up to the ack
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        prog_we && !sdram_ack |=> prog_we && $stable(prog_addr) && $stable(prog_data)
            && $stable(prog_mask));

endmodule

/* hdl/prog_if.sv */
// One packed SDRAM write moving between download pipeline stages
// Transfer on clk when valid and ready are both high

interface prog_if;
    import kicker_pkg::*;

    logic       valid;
    logic       ready;
    prog_word_u addr;
    logic [7:0] data;
    logic [1:0] mask;   // Active low byte lanes
    region_e    region;

    modport source (
        output valid,
        output addr,
        output data,
        output mask,
        output region,
        input  ready
    );

    modport sink (
        input  valid,
        input  addr,
        input  data,
        input  mask,
        input  region,
        output ready
    );

endinterface

/* project.f */
hdl/kicker_pkg.sv
hdl/prog_if.sv
hdl/kicker_dwnld.sv
hdl/kicker_gfx_reorder.sv
hdl/kicker_sdram_wr.sv
hdl/kicker_rom_load.sv
testbench/tb_kicker_rom_load.sv

/* testbench/tb_kicker_rom_load.sv */
// Testbench for the ROM download path, sends random loader bytes to every region
// A queue model predicts each SDRAM and PROM write, concurrent assertions compare

module tb_kicker_rom_load;
    import kicker_pkg::*;

    localparam int N_MAIN      = 24;
    localparam int N_SCR       = 24;
    localparam int N_OBJ       = 24;
    localparam int N_PROM      = 16;
    localparam int N_MIX       = 40;
    localparam int TOTAL_BYTES = N_MAIN + N_SCR + N_OBJ + N_PROM + N_MIX;

    logic                clk;
    logic                reset;
    logic                downloading;
    logic [IOCTL_AW-1:0] ioctl_addr;
    logic [7:0]          ioctl_dout;
    logic                ioctl_wr;
    logic                ioctl_ready;
    logic                dwnld_busy;
    logic                prom_we;
    logic [PROM_AW-1:0]  prom_addr;
    logic [7:0]          prom_data;
    logic                sdram_ack;
    logic                prog_we;
    logic [PROG_AW-1:0]  prog_addr;
    logic [7:0]          prog_data;
    logic [1:0]          prog_mask;

    logic [31:0]         lfsr_state = 32'hd87b2b93;
    logic [31:0]         exp_q[$];      // {word address, data, mask} in loader order
    logic                exp_have;
    logic [PROG_AW-1:0]  exp_addr;
    logic [7:0]          exp_data;
    logic [1:0]          exp_mask;
    logic                prom_due;      // PROM byte accepted on the last edge
    logic [PROM_AW-1:0]  exp_prom_addr;
    logic [7:0]          exp_prom_data;
    int                  sent;
    int                  acks;
    int                  ack_wait;

    kicker_rom_load dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Word address the tile fetchers expect for a loader byte
    function automatic logic [PROG_AW-1:0] expect_word(input logic [IOCTL_AW-1:0] a);
        logic [PROG_AW-1:0] w;
        logic [PROG_AW-1:0] n;
        w = a[PROG_AW:1];
        n = w;
        if (a >= IOCTL_AW'(SCR_START) && a < IOCTL_AW'(OBJ_START)) begin
            n[0]   = ~w[3];
            n[3:1] = w[2:0];
        end else if (a >= IOCTL_AW'(OBJ_START) && a < IOCTL_AW'(PROM_START)) begin
            n[0]   = ~w[3];
            n[1]   = w[4];
            n[4:2] = w[2:0];
        end
        return n;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    // Called at edge plus 5, returns at edge plus 5
    task automatic send_byte(input logic [IOCTL_AW-1:0] a);
        logic [7:0] d;
        int         gap;
        d   = 8'(take_bits(8));
        gap = int'(take_bits(2));
        while (!ioctl_ready) begin
            @(posedge clk);
            #5;
        end
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #5;
        ioctl_wr = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #5;
        end
    endtask

    function automatic logic [IOCTL_AW-1:0] pick_addr(input int region);
        case (region)
            0: return IOCTL_AW'(take_bits(15));
            1: return IOCTL_AW'(SCR_START) + IOCTL_AW'(take_bits(14));
            2: return IOCTL_AW'(OBJ_START) + IOCTL_AW'(take_bits(14));
            default: return IOCTL_AW'(PROM_START) + IOCTL_AW'(take_bits(11));
        endcase
    endfunction

    // Reference model, sees the same edge as the DUT before its registers move
    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            prom_due = 1'b0;
            sent     = 0;
            acks     = 0;
        end else begin
            if (prog_we && sdram_ack && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                acks++;
            end
            prom_due = 1'b0;
            if (ioctl_wr && ioctl_ready) begin
                if (ioctl_addr >= IOCTL_AW'(PROM_START)) begin
                    prom_due      = 1'b1;
                    exp_prom_addr = PROM_AW'(ioctl_addr - IOCTL_AW'(PROM_START));
                    exp_prom_data = ioctl_dout;
                end else begin
                    exp_q.push_back({expect_word(ioctl_addr), ioctl_dout,
                                     ioctl_addr[0] ? 2'b01 : 2'b10});
                    sent++;
                end
            end
        end
        exp_have = exp_q.size() != 0;
        if (exp_have) begin
            {exp_addr, exp_data, exp_mask} = exp_q[0];
        end
    end

    // SDRAM controller with 0 to 3 cycles of ack delay
    initial begin
        ack_wait = int'(take_bits(2));
        forever begin
            @(posedge clk);
            #4;
            if (prog_we && ack_wait == 0) begin
                sdram_ack = 1'b1;
                ack_wait  = int'(take_bits(2));
            end else begin
                sdram_ack = 1'b0;
                if (prog_we) begin
                    ack_wait--;
                end
            end
        end
    end

    a_reset_low: assert property (@(posedge clk) reset |=> !prog_we && !prom_we && !ioctl_ready)
        else report_failure($sformatf(
            "FAILED at %0t: {prog_we,prom_we,ioctl_ready} expected 000 got %b%b%b",
            $time, $sampled(prog_we), $sampled(prom_we), $sampled(ioctl_ready)));

    a_prog_pending: assert property (@(posedge clk) disable iff (reset) prog_we |-> exp_have)
        else report_failure("prog_we raised with no SDRAM write pending");

    a_prog_addr: assert property (@(posedge clk) disable iff (reset)
        prog_we && exp_have |-> prog_addr == exp_addr)
        else report_failure($sformatf("FAILED at %0t: prog_addr expected %h got %h",
            $time, $sampled(exp_addr), $sampled(prog_addr)));

    a_prog_data: assert property (@(posedge clk) disable iff (reset)
        prog_we && exp_have |-> prog_data == exp_data)
        else report_failure($sformatf("FAILED at %0t: prog_data expected %h got %h",
            $time, $sampled(exp_data), $sampled(prog_data)));

    a_prog_mask: assert property (@(posedge clk) disable iff (reset)
        prog_we && exp_have |-> prog_mask == exp_mask)
        else report_failure($sformatf("FAILED at %0t: prog_mask expected %b got %b",
            $time, $sampled(exp_mask), $sampled(prog_mask)));

    // Exactly one cycle after the PROM byte is taken
    a_prom_we: assert property (@(posedge clk) disable iff (reset) prom_we == prom_due)
        else report_failure($sformatf("FAILED at %0t: prom_we expected %b got %b",
            $time, $sampled(prom_due), $sampled(prom_we)));

    a_prom_addr: assert property (@(posedge clk) disable iff (reset)
        prom_we |-> prom_addr == exp_prom_addr)
        else report_failure($sformatf("FAILED at %0t: prom_addr expected %h got %h",
            $time, $sampled(exp_prom_addr), $sampled(prom_addr)));

    a_prom_data: assert property (@(posedge clk) disable iff (reset)
        prom_we |-> prom_data == exp_prom_data)
        else report_failure($sformatf("FAILED at %0t: prom_data expected %h got %h",
            $time, $sampled(exp_prom_data), $sampled(prom_data)));

    a_busy: assert property (@(posedge clk) disable iff (reset)
        dwnld_busy == (downloading || exp_have))
        else report_failure($sformatf("FAILED at %0t: dwnld_busy expected %b got %b",
            $time, $sampled(downloading || exp_have), $sampled(dwnld_busy)));

    initial begin
        repeat (TOTAL_BYTES * 10 + 100) @(posedge clk);
        report_failure("Run timed out without finishing");
    end

    initial begin
        reset       = 1'b1;
        downloading = 1'b1;     // Loader already up while reset is held
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        sdram_ack   = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;
        @(posedge clk);
        #5;
        for (int i = 0; i < N_MAIN; i++) send_byte(pick_addr(0));
        for (int i = 0; i < N_SCR; i++) send_byte(pick_addr(1));
        for (int i = 0; i < N_OBJ; i++) send_byte(pick_addr(2));
        for (int i = 0; i < N_PROM; i++) send_byte(pick_addr(3));
        for (int i = 0; i < N_MIX; i++) send_byte(pick_addr(int'(take_bits(2))));
        downloading = 1'b0;
        while (dwnld_busy) begin        // Drain the pipeline
            @(posedge clk);
            #5;
        end
        repeat (2) @(posedge clk);
        if (exp_q.size() != 0 || acks != sent) begin
            report_failure($sformatf("%0d SDRAM writes sent but %0d acknowledged", sent, acks));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
